/* common/mpbuf_pkg.sv */
// message buffer shared definitions.
// widths, register map, bus response codes and the send FSM states.
package mpbuf_pkg;

   // ====================
   // widths
   // ====================

   // one noc flit.
   typedef logic [31:0] flit_t;

   // one bus address or data word.
   typedef logic [31:0] bus_word_t;

   // entries per queue, which is also the longest legal message in flits.
   localparam int DEPTH = 16;
   localparam int PTR_W = $clog2(DEPTH);

   // a queue slot index wraps naturally because DEPTH is a power of two.
   typedef logic [PTR_W-1:0] ptr_t;

   // one extra bit so that a full queue of DEPTH entries can be counted.
   typedef logic [PTR_W:0] count_t;

   // ====================
   // register map
   // ====================

   // write pushes a length or a flit, read pops one receive flit.
   localparam bus_word_t ADDR_DATA   = 32'h0000_0000;
   // read only.
   localparam bus_word_t ADDR_STATUS = 32'h0000_0004;
   // bit 0 enables the interrupt.
   localparam bus_word_t ADDR_IRQ_EN = 32'h0000_0008;

   // field positions inside the status word.
   localparam int STAT_MSG_LSB      = 0;
   localparam int STAT_FREE_LSB     = 8;
   localparam int STAT_NONEMPTY_BIT = 16;

   // ====================
   // bus response codes
   // ====================

   // one bit per response kind, so ack and err can never share a code.
   typedef logic [1:0] resp_t;
   localparam resp_t RESP_NONE = 2'b00;
   localparam resp_t RESP_ACK  = 2'b01;
   localparam resp_t RESP_ERR  = 2'b10;

   // the send FSM either waits for a length word or counts flit writes.
   typedef enum logic {
      SEND_IDLE,
      SEND_FLITS
   } send_state_t;

endpackage

/* src/mpbuf_fifo.sv */
// flit queue with last marker and first-word-fall-through head.
`timescale 1ns/1ns

module mpbuf_fifo (
   input  logic              clk,
   input  logic              reset_i,

   input  logic              push_i,
   input  mpbuf_pkg::flit_t  push_flit_i,
   input  logic              push_last_i,

   input  logic              pop_i,
   output mpbuf_pkg::flit_t  head_flit_o,
   output logic              head_last_o,

   output logic              empty_o,
   output logic              full_o,
   output mpbuf_pkg::count_t count_o
);

   // storage for the flits and their last markers.
   mpbuf_pkg::flit_t  flit_mem [mpbuf_pkg::DEPTH];
   logic              last_mem [mpbuf_pkg::DEPTH];

   mpbuf_pkg::ptr_t   wr_ptr_q;
   mpbuf_pkg::ptr_t   rd_ptr_q;
   mpbuf_pkg::count_t count_q;

   // the head slot is read straight from the array, so it is valid without a pop.
   assign head_flit_o = flit_mem[rd_ptr_q];
   assign head_last_o = last_mem[rd_ptr_q];

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == mpbuf_pkg::count_t'(mpbuf_pkg::DEPTH));
   assign count_o = count_q;

   // the array itself holds data only.
   always_ff @(posedge clk) begin
      if (push_i) begin
         flit_mem[wr_ptr_q] <= push_flit_i;
         last_mem[wr_ptr_q] <= push_last_i;
      end
   end

   // pointers and occupancy.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // a push and a pop in the same cycle leave the count as it is.
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // the owner of each port is expected to look at full and empty first.
   push_when_full_a : assert property (@(posedge clk) disable iff (reset_i)
      !(push_i && full_o))
      else $error("flit pushed into a full queue");

   pop_when_empty_a : assert property (@(posedge clk) disable iff (reset_i)
      !(pop_i && empty_o))
      else $error("flit popped from an empty queue");

endmodule

/* src/mpbuf_msg_counter.sv */
// count of complete messages waiting in the receive queue.
`timescale 1ns/1ns

module mpbuf_msg_counter (
   input  logic              clk,
   input  logic              reset_i,
   input  logic              inc_i,
   input  logic              dec_i,
   output mpbuf_pkg::count_t count_o,
   output logic              nonzero_o
);

   mpbuf_pkg::count_t count_q;

   // inc marks a last flit entering the queue, dec marks one leaving it.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         count_q <= '0;
      end else if (inc_i && !dec_i) begin
         count_q <= count_q + 1'b1;
      end else if (dec_i && !inc_i) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign count_o   = count_q;
   assign nonzero_o = (count_q != '0);

   // a message can only leave once its last flit arrived.
   // the queue never holds more than DEPTH last flits.
   msg_count_range_a : assert property (@(posedge clk) disable iff (reset_i)
      !(dec_i && !inc_i && count_q == '0) &&
      !(inc_i && !dec_i && count_q == mpbuf_pkg::count_t'(mpbuf_pkg::DEPTH)))
      else $error("message count left its range");

endmodule

/* src/mpbuf_send_fsm.sv */
// send path sequencer, takes a length word and then tags the last flit write.
`timescale 1ns/1ns

module mpbuf_send_fsm (
   input  logic                 clk,
   input  logic                 reset_i,
   input  logic                 wr_i,
   input  mpbuf_pkg::bus_word_t wr_data_i,
   output logic                 len_ok_o,
   output logic                 push_o,
   output logic                 last_o
);

   mpbuf_pkg::send_state_t state_q;
   mpbuf_pkg::count_t      remaining_q;
   logic                   len_legal;

   // ====================
   // answers to the core
   // ====================

   // a legal length lies between one flit and a full queue.
   assign len_legal = (wr_data_i != '0) &&
                      (wr_data_i <= mpbuf_pkg::bus_word_t'(mpbuf_pkg::DEPTH));

   // these only look at the state and the data on the bus.
   // the core combines them with the queue state before it commits a write.
   assign len_ok_o = (state_q == mpbuf_pkg::SEND_IDLE) && len_legal;
   assign push_o   = (state_q == mpbuf_pkg::SEND_FLITS);
   assign last_o   = (state_q == mpbuf_pkg::SEND_FLITS) && (remaining_q == 'd1);

   // ====================
   // state
   // ====================

   // wr_i only pulses for writes that the core acknowledges.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q     <= mpbuf_pkg::SEND_IDLE;
         remaining_q <= '0;
      end else if (wr_i) begin
         case (state_q)
            mpbuf_pkg::SEND_IDLE: begin
               if (len_ok_o) begin
                  remaining_q <= wr_data_i[$bits(mpbuf_pkg::count_t)-1:0];
                  state_q     <= mpbuf_pkg::SEND_FLITS;
               end
            end
            mpbuf_pkg::SEND_FLITS: begin
               remaining_q <= remaining_q - 1'b1;
               // the flit that carries last closes the message.
               if (last_o) begin
                  state_q <= mpbuf_pkg::SEND_IDLE;
               end
            end
            default: state_q <= mpbuf_pkg::SEND_IDLE;
         endcase
      end
   end

   // while flits are expected at least one of them is still missing.
   remaining_nonzero_a : assert property (@(posedge clk) disable iff (reset_i)
      (state_q == mpbuf_pkg::SEND_FLITS) |-> (remaining_q != '0))
      else $error("send FSM expects flits with a zero count");

   // the core must never commit an illegal length
   committed_len_legal_a : assert property (@(posedge clk) disable iff (reset_i)
      (wr_i && state_q == mpbuf_pkg::SEND_IDLE) |-> len_ok_o)
      else $error("illegal length reached the send FSM");

endmodule

/* mpbuffer/mpbuffer.sv */
// message buffer core on a generic bus.
// decodes registers, answers with ack or err and moves flits between bus and noc.
`timescale 1ns/1ns

module mpbuffer (
   input  logic                 clk,
   input  logic                 reset_i,

   input  mpbuf_pkg::bus_word_t bus_addr_i,
   input  mpbuf_pkg::bus_word_t bus_data_i,
   output mpbuf_pkg::bus_word_t bus_data_o,
   input  logic                 bus_we_i,
   input  logic                 bus_en_i,
   output logic                 bus_ack_o,
   output logic                 bus_err_o,

   output mpbuf_pkg::flit_t     noc_out_flit_o,
   output logic                 noc_out_last_o,
   output logic                 noc_out_valid_o,
   input  logic                 noc_out_ready_i,

   input  mpbuf_pkg::flit_t     noc_in_flit_i,
   input  logic                 noc_in_last_i,
   input  logic                 noc_in_valid_i,
   output logic                 noc_in_ready_o,

   output logic                 irq_o
);

   mpbuf_pkg::resp_t     resp_q;
   mpbuf_pkg::bus_word_t rd_data_q;
   mpbuf_pkg::bus_word_t rd_data;
   mpbuf_pkg::bus_word_t status;
   logic                 irq_en_q;
   logic                 irq_q;

   logic accept, req_ok, commit;
   logic is_data, is_status, is_irq_en;
   logic data_wr;

   // send side
   logic              len_ok, flit_req, flit_last;
   logic              tx_push, tx_pop, tx_empty, tx_full;
   mpbuf_pkg::count_t tx_count;

   // receive side
   logic              rx_push, rx_pop, rx_empty, rx_full, rx_head_last;
   mpbuf_pkg::flit_t  rx_head_flit;
   mpbuf_pkg::count_t msg_count;
   logic              msg_nonzero;

   // ====================
   // request decode
   // ====================

   // after each response one idle cycle lets the master drop its strobe.
   assign accept = bus_en_i && (resp_q == mpbuf_pkg::RESP_NONE);

   assign is_data   = (bus_addr_i == mpbuf_pkg::ADDR_DATA);
   assign is_status = (bus_addr_i == mpbuf_pkg::ADDR_STATUS);
   assign is_irq_en = (bus_addr_i == mpbuf_pkg::ADDR_IRQ_EN);

   // in SEND_FLITS every data write is a flit, otherwise it must be a legal length.
   // reads of the data register need a flit, the status register is read only.
   always_comb begin
      req_ok = 1'b0;
      if (is_data) begin
         if (bus_we_i) begin
            req_ok = len_ok || (flit_req && !tx_full);
         end else begin
            req_ok = !rx_empty;
         end
      end else if (is_status) begin
         req_ok = !bus_we_i;
      end else if (is_irq_en) begin
         req_ok = 1'b1;
      end
   end

   // side effects only happen for requests that will be acknowledged.
   assign commit  = accept && req_ok;
   assign data_wr = commit && is_data && bus_we_i;
   assign tx_push = data_wr && flit_req;
   assign rx_pop  = commit && is_data && !bus_we_i;

   // the status word holds the message count, the send free space and the receive not-empty flag.
   always_comb begin
      status = '0;
      status[mpbuf_pkg::STAT_MSG_LSB +: $bits(mpbuf_pkg::count_t)] = msg_count;
      status[mpbuf_pkg::STAT_FREE_LSB +: $bits(mpbuf_pkg::count_t)] =
         mpbuf_pkg::count_t'(mpbuf_pkg::DEPTH) - tx_count;
      status[mpbuf_pkg::STAT_NONEMPTY_BIT] = !rx_empty;
   end

   always_comb begin
      rd_data = '0;
      if (req_ok && !bus_we_i) begin
         if (is_data) begin
            rd_data = rx_head_flit;
         end else if (is_status) begin
            rd_data = status;
         end else begin
            rd_data = {31'b0, irq_en_q};
         end
      end
   end

   // ====================
   // response and registers
   // ====================

   always_ff @(posedge clk) begin
      if (reset_i) begin
         resp_q   <= mpbuf_pkg::RESP_NONE;
         irq_en_q <= 1'b0;
         irq_q    <= 1'b0;
      end else begin
         if (accept) begin
            resp_q <= req_ok ? mpbuf_pkg::RESP_ACK : mpbuf_pkg::RESP_ERR;
         end else begin
            resp_q <= mpbuf_pkg::RESP_NONE;
         end
         if (commit && is_irq_en && bus_we_i) begin
            irq_en_q <= bus_data_i[0];
         end
         // the interrupt follows count and enable one cycle later.
         irq_q <= irq_en_q && msg_nonzero;
      end
   end

   // read data is sampled together with the response.
   always_ff @(posedge clk) begin
      if (accept) begin
         rd_data_q <= rd_data;
      end
   end

   assign bus_ack_o  = (resp_q == mpbuf_pkg::RESP_ACK);
   assign bus_err_o  = (resp_q == mpbuf_pkg::RESP_ERR);
   assign bus_data_o = rd_data_q;
   assign irq_o      = irq_q;

   // ====================
   // send path
   // ====================

   mpbuf_send_fsm send_fsm_i (
      .clk       (clk),
      .reset_i   (reset_i),
      .wr_i      (data_wr),
      .wr_data_i (bus_data_i),
      .len_ok_o  (len_ok),
      .push_o    (flit_req),
      .last_o    (flit_last)
   );

   // the noc side drains the queue whenever it is ready.
   assign noc_out_valid_o = !tx_empty;
   assign tx_pop          = noc_out_valid_o && noc_out_ready_i;

   mpbuf_fifo tx_fifo_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .push_i      (tx_push),
      .push_flit_i (bus_data_i),
      .push_last_i (flit_last),
      .pop_i       (tx_pop),
      .head_flit_o (noc_out_flit_o),
      .head_last_o (noc_out_last_o),
      .empty_o     (tx_empty),
      .full_o      (tx_full),
      .count_o     (tx_count)
   );

   // ====================
   // receive path
   // ====================

   assign noc_in_ready_o = !rx_full;
   assign rx_push        = noc_in_valid_i && noc_in_ready_o;

   // rx occupancy is not reported, only whether a flit is present.
   mpbuf_fifo rx_fifo_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .push_i      (rx_push),
      .push_flit_i (noc_in_flit_i),
      .push_last_i (noc_in_last_i),
      .pop_i       (rx_pop),
      .head_flit_o (rx_head_flit),
      .head_last_o (rx_head_last),
      .empty_o     (rx_empty),
      .full_o      (rx_full),
      .count_o     ()
   );

   mpbuf_msg_counter msg_counter_i (
      .clk       (clk),
      .reset_i   (reset_i),
      .inc_i     (rx_push && noc_in_last_i),
      .dec_i     (rx_pop && rx_head_last),
      .count_o   (msg_count),
      .nonzero_o (msg_nonzero)
   );

   // a response is either ack or err, never both.
   resp_onehot_a : assert property (@(posedge clk) disable iff (reset_i)
      !(bus_ack_o && bus_err_o))
      else $error("ack and err raised together");

endmodule

/* mpbuffer/mpbuffer_wb.sv */
// Wishbone slave top level of the message buffer.
`timescale 1ns/1ns

module mpbuffer_wb (
   input  logic                 clk,
   input  logic                 reset_i,

   output mpbuf_pkg::flit_t     noc_out_flit_o,
   output logic                 noc_out_last_o,
   output logic                 noc_out_valid_o,
   input  logic                 noc_out_ready_i,

   input  mpbuf_pkg::flit_t     noc_in_flit_i,
   input  logic                 noc_in_last_i,
   input  logic                 noc_in_valid_i,
   output logic                 noc_in_ready_o,

   input  mpbuf_pkg::bus_word_t wb_adr_i,
   input  mpbuf_pkg::bus_word_t wb_dat_i,
   output mpbuf_pkg::bus_word_t wb_dat_o,
   input  logic                 wb_we_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,

   output logic                 irq_o
);

   // a Wishbone request is live only while both cycle and strobe are high.
   logic bus_en;

   assign bus_en = wb_cyc_i && wb_stb_i;

   mpbuffer buffer_i (
      .clk             (clk),
      .reset_i         (reset_i),
      .bus_addr_i      (wb_adr_i),
      .bus_data_i      (wb_dat_i),
      .bus_data_o      (wb_dat_o),
      .bus_we_i        (wb_we_i),
      .bus_en_i        (bus_en),
      .bus_ack_o       (wb_ack_o),
      .bus_err_o       (wb_err_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_last_o  (noc_out_last_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_last_i   (noc_in_last_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .irq_o           (irq_o)
   );

endmodule

/* verif/tb_mpbuffer.sv */
// testbench for the Wishbone message buffer.
// applies a table of bus accesses and NoC injections and checks the outgoing flits.
`timescale 1ns/1ns

module tb_mpbuffer;

   localparam int RESET_CYCLES = 16;
   localparam int CYCLES_PER_ROW = 40;

   // ====================
   // stimulus table
   // ====================

   // WRF is a flit write that is expected to be acked and to leave on noc_out.
   typedef enum logic [3:0] {
      OP_WR, OP_WRF, OP_RD, OP_INJ, OP_SINK, OP_DRAIN, OP_IRQ, OP_INRDY
   } op_t;

   // for WRF and INJ, exp bit 0 is the last flag of the final repetition.
   // for IRQ and INRDY, exp bit 0 is the expected level.
   typedef struct packed {
      op_t                  op;
      mpbuf_pkg::bus_word_t addr;
      mpbuf_pkg::bus_word_t data;
      logic                 err;
      mpbuf_pkg::bus_word_t exp;
      mpbuf_pkg::bus_word_t rep;
   } row_t;

   // the data field of a SINK row selects the mode of the NoC sink.
   localparam mpbuf_pkg::bus_word_t SINK_LOW    = 32'd0;
   localparam mpbuf_pkg::bus_word_t SINK_RANDOM = 32'd1;
   localparam mpbuf_pkg::bus_word_t SINK_HIGH   = 32'd2;

   logic                 clk = 1'b0;
   logic                 reset_i;
   mpbuf_pkg::flit_t     noc_out_flit_o;
   logic                 noc_out_last_o;
   logic                 noc_out_valid_o;
   logic                 noc_out_ready_i = 1'b0;
   mpbuf_pkg::flit_t     noc_in_flit_i;
   logic                 noc_in_last_i;
   logic                 noc_in_valid_i;
   logic                 noc_in_ready_o;
   mpbuf_pkg::bus_word_t wb_adr_i;
   mpbuf_pkg::bus_word_t wb_dat_i;
   mpbuf_pkg::bus_word_t wb_dat_o;
   logic                 wb_we_i;
   logic                 wb_cyc_i;
   logic                 wb_stb_i;
   logic                 wb_ack_o;
   logic                 wb_err_o;
   logic                 irq_o;

   row_t       rows [$];
   logic [32:0] exp_flits [$];
   logic [32:0] sink_exp;
   logic [1:0]  sink_mode = 2'd0;
   logic        table_ready = 1'b0;
   int          seed = 36;
   int          rnd;
   int          errors = 0;
   int          checks = 0;

   mpbuffer_wb dut_i (
      .clk             (clk),
      .reset_i         (reset_i),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_last_o  (noc_out_last_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_last_i   (noc_in_last_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .wb_adr_i        (wb_adr_i),
      .wb_dat_i        (wb_dat_i),
      .wb_dat_o        (wb_dat_o),
      .wb_we_i         (wb_we_i),
      .wb_cyc_i        (wb_cyc_i),
      .wb_stb_i        (wb_stb_i),
      .wb_ack_o        (wb_ack_o),
      .wb_err_o        (wb_err_o),
      .irq_o           (irq_o)
   );

   always #50 clk = ~clk;

   task automatic check(input mpbuf_pkg::bus_word_t got, input mpbuf_pkg::bus_word_t exp,
                        input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED @%0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // the status word packs the message count at bit 0, the send free space at bit 8
   // and the receive not-empty flag at bit 16.
   function automatic mpbuf_pkg::bus_word_t status_word(input int msgs, input int free,
                                                        input bit nonempty);
      return mpbuf_pkg::bus_word_t'(msgs) | (mpbuf_pkg::bus_word_t'(free) << 8) |
             (mpbuf_pkg::bus_word_t'(nonempty) << 16);
   endfunction

   task automatic add_row(input op_t op, input mpbuf_pkg::bus_word_t addr,
                          input mpbuf_pkg::bus_word_t data, input logic err,
                          input mpbuf_pkg::bus_word_t exp, input int rep = 1);
      row_t r;
      r.op   = op;
      r.addr = addr;
      r.data = data;
      r.err  = err;
      r.exp  = exp;
      r.rep  = mpbuf_pkg::bus_word_t'(rep);
      rows.push_back(r);
   endtask

   task automatic build_table;
      // one message of three flits goes out while the sink is always ready.
      add_row(OP_SINK, 0, SINK_HIGH, 0, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd3, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h11, 0, 32'd1, 3);
      add_row(OP_DRAIN, 0, 0, 0, 0);
      // back-to-back messages under random back-pressure.
      add_row(OP_SINK, 0, SINK_RANDOM, 0, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd2, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h21, 0, 32'd1, 2);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd1, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h31, 0, 32'd1);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd3, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h41, 0, 32'd1, 3);
      add_row(OP_DRAIN, 0, 0, 0, 0);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(0, mpbuf_pkg::DEPTH, 0));
      // receive a two-flit message with the interrupt enabled.
      add_row(OP_WR, mpbuf_pkg::ADDR_IRQ_EN, 32'd1, 0, 0);
      add_row(OP_RD, mpbuf_pkg::ADDR_IRQ_EN, 0, 0, 32'd1);
      add_row(OP_INJ, 0, 32'hA1, 0, 32'd1, 2);
      add_row(OP_IRQ, 0, 0, 0, 32'd1);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(1, mpbuf_pkg::DEPTH, 1));
      add_row(OP_RD, mpbuf_pkg::ADDR_DATA, 0, 0, 32'hA1, 2);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(0, mpbuf_pkg::DEPTH, 0));
      add_row(OP_IRQ, 0, 0, 0, 32'd0);
      // illegal accesses come first and the reads after them show that nothing moved.
      add_row(OP_RD, mpbuf_pkg::ADDR_DATA, 0, 1, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd0, 1, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, mpbuf_pkg::DEPTH + 1, 1, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_STATUS, 32'd5, 1, 0);
      add_row(OP_RD, 32'hC, 0, 1, 0);
      add_row(OP_WR, 32'hC, 32'd0, 1, 0);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(0, mpbuf_pkg::DEPTH, 0));
      add_row(OP_RD, mpbuf_pkg::ADDR_IRQ_EN, 0, 0, 32'd1);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd1, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h51, 0, 32'd1);
      add_row(OP_DRAIN, 0, 0, 0, 0);
      // the send queue fills while the sink stalls and the message still lacks its last flit.
      add_row(OP_SINK, 0, SINK_LOW, 0, 0);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'd1, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h100, 0, 32'd1);
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, mpbuf_pkg::DEPTH, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h200, 0, 32'd0, mpbuf_pkg::DEPTH - 1);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(0, 0, 0));
      add_row(OP_WR, mpbuf_pkg::ADDR_DATA, 32'h2FF, 1, 0);
      add_row(OP_SINK, 0, SINK_HIGH, 0, 0);
      add_row(OP_DRAIN, 0, 0, 0, 0);
      add_row(OP_WRF, mpbuf_pkg::ADDR_DATA, 32'h20F, 0, 32'd1);
      add_row(OP_DRAIN, 0, 0, 0, 0);
      // one long message fills the receive queue and is then read back.
      add_row(OP_INJ, 0, 32'h300, 0, 32'd1, mpbuf_pkg::DEPTH);
      add_row(OP_INRDY, 0, 0, 0, 32'd0);
      add_row(OP_IRQ, 0, 0, 0, 32'd1);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(1, mpbuf_pkg::DEPTH, 1));
      add_row(OP_RD, mpbuf_pkg::ADDR_DATA, 0, 0, 32'h300);
      add_row(OP_INRDY, 0, 0, 0, 32'd1);
      add_row(OP_RD, mpbuf_pkg::ADDR_DATA, 0, 0, 32'h301, mpbuf_pkg::DEPTH - 1);
      add_row(OP_RD, mpbuf_pkg::ADDR_STATUS, 0, 0, status_word(0, mpbuf_pkg::DEPTH, 0));
      add_row(OP_IRQ, 0, 0, 0, 32'd0);
   endtask

   // ====================
   // bus and NoC drivers
   // ====================

   // the response is due one cycle after acceptance, so the second falling edge sees it.
   task automatic bus_access(input logic we, input mpbuf_pkg::bus_word_t adr,
                             input mpbuf_pkg::bus_word_t dat, output logic err,
                             output mpbuf_pkg::bus_word_t rdata);
      int waits;
      waits = 0;
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      do begin
         @(negedge clk);
         waits++;
      end while (!(wb_ack_o || wb_err_o));
      check(32'(waits), 32'd2, "bus response latency");
      err   = wb_err_o;
      rdata = wb_dat_o;
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   // the flit is taken at the first rising edge that finds ready high.
   task automatic inject(input mpbuf_pkg::flit_t flit, input logic last);
      @(posedge clk);
      noc_in_valid_i <= 1'b1;
      noc_in_flit_i  <= flit;
      noc_in_last_i  <= last;
      do @(negedge clk); while (!noc_in_ready_o);
      @(posedge clk);
      noc_in_valid_i <= 1'b0;
   endtask

   task automatic apply_row(input row_t r);
      logic                 err;
      logic                 last;
      mpbuf_pkg::bus_word_t rdata;
      for (int k = 0; k < int'(r.rep); k++) begin
         last = r.exp[0] && (k == int'(r.rep) - 1);
         case (r.op)
            OP_WR, OP_RD: begin
               bus_access(r.op == OP_WR, r.addr, r.data + k, err, rdata);
               check(32'(err), 32'(r.err), "bus response is err");
               if (r.op == OP_RD && !r.err) begin
                  check(rdata, r.exp + k, "read data");
               end
            end
            OP_WRF: begin
               // the flit is queued first because it may leave before the ack is seen.
               exp_flits.push_back({last, r.data + k});
               bus_access(1'b1, r.addr, r.data + k, err, rdata);
               check(32'(err), 32'd0, "flit write is err");
            end
            OP_INJ: inject(r.data + k, last);
            OP_SINK: begin
               @(negedge clk);
               sink_mode = r.data[1:0];
            end
            OP_DRAIN: begin
               do @(negedge clk); while (exp_flits.size() != 0 || noc_out_valid_o);
            end
            OP_IRQ: begin
               // irq_o trails the message count by one register stage.
               repeat (2) @(negedge clk);
               check(32'(irq_o), 32'(r.exp[0]), "irq_o level");
            end
            default: begin
               repeat (2) @(negedge clk);
               check(32'(noc_in_ready_o), 32'(r.exp[0]), "noc_in_ready_o level");
            end
         endcase
      end
   endtask

   // ====================
   // NoC sink
   // ====================

   always @(posedge clk) begin
      rnd = $random(seed);
      if (reset_i || sink_mode == SINK_LOW[1:0]) begin
         noc_out_ready_i <= 1'b0;
      end else if (sink_mode == SINK_RANDOM[1:0]) begin
         noc_out_ready_i <= rnd[0];
      end else begin
         noc_out_ready_i <= 1'b1;
      end
   end

   // a flit seen with valid and ready here transfers at the next rising edge.
   always @(negedge clk) begin
      if (!reset_i && noc_out_valid_o && noc_out_ready_i) begin
         if (exp_flits.size() == 0) begin
            errors++;
            $display("unexpected flit %h left on noc_out at %0t ns", noc_out_flit_o, $time);
         end else begin
            sink_exp = exp_flits.pop_front();
            check(noc_out_flit_o, sink_exp[31:0], "noc_out flit");
            check(32'(noc_out_last_o), 32'(sink_exp[32]), "noc_out last flag");
         end
      end
   end

   // ====================
   // main sequence and watchdog
   // ====================

   initial begin
      reset_i        <= 1'b1;
      wb_adr_i       <= '0;
      wb_dat_i       <= '0;
      wb_we_i        <= 1'b0;
      wb_cyc_i       <= 1'b0;
      wb_stb_i       <= 1'b0;
      noc_in_flit_i  <= '0;
      noc_in_last_i  <= 1'b0;
      noc_in_valid_i <= 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_i <= 1'b0;
      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      if (exp_flits.size() != 0) begin
         errors++;
         $display("%0d expected flits never left on noc_out", exp_flits.size());
      end
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      wait (table_ready);
      repeat (RESET_CYCLES + rows.size() * CYCLES_PER_ROW) @(posedge clk);
      $display("timeout, the table of %0d rows did not finish in time", rows.size());
      $display("Regression failed");
      $finish;
   end

endmodule

/* tb.f */
common/mpbuf_pkg.sv
src/mpbuf_fifo.sv
src/mpbuf_msg_counter.sv
src/mpbuf_send_fsm.sv
mpbuffer/mpbuffer.sv
mpbuffer/mpbuffer_wb.sv
verif/tb_mpbuffer.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_mpbuffer
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
